// ==== design/sim_host_pkg.sv ====
// Shared definitions for the host-side memory subsystem
// Bus widths, RAM geometry and queue sizing
// Address map and host register offsets
// Request and response structs for the loader and core ports

`default_nettype none

package sim_host_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Backing RAM geometry, indexed by the low address bits
  localparam int RAM_WORDS  = 1024;
  localparam int RAM_ADDR_W = 10;

  // Host control block sizing
  localparam int NUM_CORES = 4;
  localparam int NUM_TRACE = 8;
  localparam int RT_DIV    = 8;
  localparam int RT_PRE_W  = $clog2(RT_DIV);

  // Request queue sizing
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Address map, top address bit picks the host block over RAM
  localparam int HOST_SEL_BIT = 15;
  localparam int HOST_OFS_W   = HOST_SEL_BIT;

  // Host register word offsets
  localparam logic [HOST_OFS_W-1:0] REG_FINISH  = 'd0;
  localparam logic [HOST_OFS_W-1:0] REG_TRACE   = 'd1;
  localparam logic [HOST_OFS_W-1:0] REG_RT_TIME = 'd2;

  // Loader write, always a store
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } load_pkt_t;

  // Core memory command
  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_cmd_t;

  // Routed request toward RAM or the host block
  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_t;

  // Core response, zero data for writes
  typedef struct packed {
    logic [DATA_W-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

// ==== design/request_queue.sv ====
// Small circular FIFO for strobed requests of one port
// Payload type is a parameter so both ports share this block
// A push into a full queue is dropped

`default_nettype none

module request_queue #(
  parameter type payload_t = logic
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic push_i,
  input  payload_t  data_i,
  input  wire logic pop_i,
  output payload_t  head_o,
  output logic      valid_o
);

  payload_t mem_q [sim_host_pkg::QUEUE_DEPTH];

  logic [sim_host_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [sim_host_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [sim_host_pkg::QUEUE_CNT_W-1:0] count_q;
  logic                                 do_push;
  logic                                 do_pop;

  assign do_push = push_i && (count_q != sim_host_pkg::QUEUE_DEPTH);
  assign do_pop  = pop_i && (count_q != '0);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= (wr_ptr_q == sim_host_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= (rd_ptr_q == sim_host_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
// Round-robin arbiter between the loader and core request queues
// Routes the granted request to RAM or the host block by address
// Returns one response per core command, a cycle after its grant

`default_nettype none

module bus_arbiter (
  input  wire logic                                 clk_i,
  input  wire logic                                 reset_i,
  input  sim_host_pkg::load_pkt_t                   load_head_i,
  input  wire logic                                 load_valid_i,
  output logic                                      load_pop_o,
  input  sim_host_pkg::mem_cmd_t                    core_head_i,
  input  wire logic                                 core_valid_i,
  output logic                                      core_pop_o,
  output sim_host_pkg::mem_req_t                    req_o,
  output logic                                      ram_sel_o,
  output logic                                      host_sel_o,
  input  wire logic [sim_host_pkg::DATA_W-1:0]      ram_rdata_i,
  input  wire logic [sim_host_pkg::DATA_W-1:0]      host_rdata_i,
  output sim_host_pkg::mem_resp_t                   core_resp_o,
  output logic                                      core_resp_v_o
);

  logic                   grant_core;
  logic                   grant_load;
  logic                   to_host;
  logic                   last_core_q;
  sim_host_pkg::mem_req_t req;

  // Outstanding core response state
  logic resp_v_q;
  logic resp_host_q;
  logic resp_wr_q;

  // Core wins a tie only if the loader was served last
  always_comb
  begin
    grant_core = core_valid_i && (!load_valid_i || !last_core_q);
    grant_load = load_valid_i && !grant_core;
  end

  always_comb
  begin
    if (grant_core)
    begin
      req.wr   = core_head_i.wr;
      req.addr = core_head_i.addr;
      req.data = core_head_i.data;
    end
    else
    begin
      req.wr   = 1'b1;
      req.addr = load_head_i.addr;
      req.data = load_head_i.data;
    end
  end

  assign to_host    = req.addr[sim_host_pkg::HOST_SEL_BIT];
  assign req_o      = req;
  assign ram_sel_o  = (grant_core || grant_load) && !to_host;
  assign host_sel_o = (grant_core || grant_load) && to_host;
  assign load_pop_o = grant_load;
  assign core_pop_o = grant_core;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      last_core_q <= 1'b0;
      resp_v_q    <= 1'b0;
    end
    else
    begin
      if (grant_core || grant_load)
      begin
        last_core_q <= grant_core;
      end
      resp_v_q <= grant_core;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (grant_core)
    begin
      resp_host_q <= to_host;
      resp_wr_q   <= core_head_i.wr;
    end
  end

  // Targets hold registered read data for exactly this cycle
  always_comb
  begin
    if (resp_wr_q)
    begin
      core_resp_o.data = '0;
    end
    else if (resp_host_q)
    begin
      core_resp_o.data = host_rdata_i;
    end
    else
    begin
      core_resp_o.data = ram_rdata_i;
    end
  end

  assign core_resp_v_o = resp_v_q;

endmodule

`default_nettype wire

// ==== design/backing_ram.sv ====
// Single-port word RAM behind the arbiter
// Write on a selected store, registered read on every selected access

`default_nettype none

module backing_ram (
  input  wire logic                            clk_i,
  input  wire logic                            sel_i,
  input  sim_host_pkg::mem_req_t               req_i,
  output logic [sim_host_pkg::DATA_W-1:0]      rdata_o
);

  logic [sim_host_pkg::DATA_W-1:0]     mem_q [sim_host_pkg::RAM_WORDS];
  logic [sim_host_pkg::DATA_W-1:0]     rdata_q;
  logic [sim_host_pkg::RAM_ADDR_W-1:0] idx;

  // Upper address bits are ignored, so the RAM aliases
  assign idx = req_i.addr[sim_host_pkg::RAM_ADDR_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (sel_i)
    begin
      if (req_i.wr)
      begin
        mem_q[idx] <= req_i.data;
      end
      // Old contents on a write, the arbiter discards them
      rdata_q <= mem_q[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== design/host_ctrl.sv ====
// Host control block registers
// Sticky per-core finish flags and trace-enable bits
// Free-running real-time counter stepping once every RT_DIV clocks
// Registered read data and registered finish and trace outputs

`default_nettype none

module host_ctrl (
  input  wire logic                               clk_i,
  input  wire logic                               reset_i,
  input  wire logic                               sel_i,
  input  sim_host_pkg::mem_req_t                  req_i,
  output logic [sim_host_pkg::DATA_W-1:0]         rdata_o,
  output logic [sim_host_pkg::NUM_CORES-1:0]      finish_o,
  output logic [sim_host_pkg::NUM_TRACE-1:0]      trace_en_o
);

  logic [sim_host_pkg::HOST_OFS_W-1:0] ofs;
  logic [sim_host_pkg::NUM_CORES-1:0]  finish_q;
  logic [sim_host_pkg::NUM_TRACE-1:0]  trace_q;
  logic [sim_host_pkg::NUM_CORES-1:0]  finish_out_q;
  logic [sim_host_pkg::NUM_TRACE-1:0]  trace_out_q;
  logic [sim_host_pkg::RT_PRE_W-1:0]   pre_q;
  logic [sim_host_pkg::DATA_W-1:0]     rt_time_q;
  logic [sim_host_pkg::DATA_W-1:0]     rdata_d;
  logic [sim_host_pkg::DATA_W-1:0]     rdata_q;

  assign ofs = req_i.addr[sim_host_pkg::HOST_OFS_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      finish_q     <= '0;
      trace_q      <= '0;
      finish_out_q <= '0;
      trace_out_q  <= '0;
    end
    else
    begin
      if (sel_i && req_i.wr && ofs == sim_host_pkg::REG_FINISH)
      begin
        finish_q <= finish_q | req_i.data[sim_host_pkg::NUM_CORES-1:0];
      end
      if (sel_i && req_i.wr && ofs == sim_host_pkg::REG_TRACE)
      begin
        trace_q <= req_i.data[sim_host_pkg::NUM_TRACE-1:0];
      end
      finish_out_q <= finish_q;
      trace_out_q  <= trace_q;
    end
  end

  // Prescaler wraps after RT_DIV clocks and steps the counter
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pre_q     <= '0;
      rt_time_q <= '0;
    end
    else if (pre_q == sim_host_pkg::RT_DIV - 1)
    begin
      pre_q     <= '0;
      rt_time_q <= rt_time_q + 1'b1;
    end
    else
    begin
      pre_q <= pre_q + 1'b1;
    end
  end

  always_comb
  begin
    rdata_d = '0;
    case (ofs)
      sim_host_pkg::REG_FINISH:  rdata_d[sim_host_pkg::NUM_CORES-1:0] = finish_q;
      sim_host_pkg::REG_TRACE:   rdata_d[sim_host_pkg::NUM_TRACE-1:0] = trace_q;
      sim_host_pkg::REG_RT_TIME: rdata_d = rt_time_q;
      default:                   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (sel_i)
    begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o    = rdata_q;
  assign finish_o   = finish_out_q;
  assign trace_en_o = trace_out_q;

endmodule

`default_nettype wire

// ==== design/sim_host_top.sv ====
// Top level of the host-side memory subsystem
// One request queue per port feeding the round-robin arbiter
// Arbiter routes to the backing RAM or the host control block

`default_nettype none

module sim_host_top (
  input  wire logic                               clk_i,
  input  wire logic                               reset_i,
  input  sim_host_pkg::load_pkt_t                 load_pkt_i,
  input  wire logic                               load_v_i,
  input  sim_host_pkg::mem_cmd_t                  core_cmd_i,
  input  wire logic                               core_cmd_v_i,
  output sim_host_pkg::mem_resp_t                 core_resp_o,
  output logic                                    core_resp_v_o,
  output logic [sim_host_pkg::NUM_CORES-1:0]      finish_o,
  output logic [sim_host_pkg::NUM_TRACE-1:0]      trace_en_o
);

  sim_host_pkg::load_pkt_t         load_head;
  logic                            load_valid;
  logic                            load_pop;
  sim_host_pkg::mem_cmd_t          core_head;
  logic                            core_valid;
  logic                            core_pop;
  sim_host_pkg::mem_req_t          req;
  logic                            ram_sel;
  logic                            host_sel;
  logic [sim_host_pkg::DATA_W-1:0] ram_rdata;
  logic [sim_host_pkg::DATA_W-1:0] host_rdata;

  request_queue #(
    .payload_t(sim_host_pkg::load_pkt_t)
  ) i_load_queue (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (load_v_i),
    .data_i (load_pkt_i),
    .pop_i  (load_pop),
    .head_o (load_head),
    .valid_o(load_valid)
  );

  request_queue #(
    .payload_t(sim_host_pkg::mem_cmd_t)
  ) i_core_queue (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (core_cmd_v_i),
    .data_i (core_cmd_i),
    .pop_i  (core_pop),
    .head_o (core_head),
    .valid_o(core_valid)
  );

  bus_arbiter i_bus_arbiter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .load_head_i  (load_head),
    .load_valid_i (load_valid),
    .load_pop_o   (load_pop),
    .core_head_i  (core_head),
    .core_valid_i (core_valid),
    .core_pop_o   (core_pop),
    .req_o        (req),
    .ram_sel_o    (ram_sel),
    .host_sel_o   (host_sel),
    .ram_rdata_i  (ram_rdata),
    .host_rdata_i (host_rdata),
    .core_resp_o  (core_resp_o),
    .core_resp_v_o(core_resp_v_o)
  );

  backing_ram i_backing_ram (
    .clk_i  (clk_i),
    .sel_i  (ram_sel),
    .req_i  (req),
    .rdata_o(ram_rdata)
  );

  host_ctrl i_host_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sel_i     (host_sel),
    .req_i     (req),
    .rdata_o   (host_rdata),
    .finish_o  (finish_o),
    .trace_en_o(trace_en_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_sim_host.sv ====
// Testbench for the host-side memory subsystem
// LFSR stimulus on the loader and core ports
// Reference RAM image, host register model and in-order response checks

`default_nettype none

module tb_sim_host;

  localparam int RESET_CYCLES = 16;
  localparam int N_LOAD = 16;
  localparam int N_RW   = 24;
  localparam int N_CONC = 16;
  // Two cycles per op plus drains, host and timer tests, then margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 6 * (2 * N_LOAD + N_RW + N_CONC) + 200;
  localparam logic [sim_host_pkg::ADDR_W-1:0] HOST_BASE = 1 << sim_host_pkg::HOST_SEL_BIT;

  typedef struct packed {
    logic                            chk;
    logic [sim_host_pkg::DATA_W-1:0] data;
    int                              cyc;
  } exp_t;

  logic                               clk_i;
  logic                               reset_i;
  sim_host_pkg::load_pkt_t            load_pkt_i;
  logic                               load_v_i;
  sim_host_pkg::mem_cmd_t             core_cmd_i;
  logic                               core_cmd_v_i;
  sim_host_pkg::mem_resp_t            core_resp_o;
  logic                               core_resp_v_o;
  logic [sim_host_pkg::NUM_CORES-1:0] finish_o;
  logic [sim_host_pkg::NUM_TRACE-1:0] trace_en_o;

  // Reference model
  logic [sim_host_pkg::DATA_W-1:0]    ram_model [sim_host_pkg::RAM_WORDS];
  bit                                 ram_known [sim_host_pkg::RAM_WORDS];
  logic [sim_host_pkg::NUM_CORES-1:0] finish_model;
  logic [sim_host_pkg::NUM_TRACE-1:0] trace_model;
  exp_t                               exp_q [$];
  exp_t                               resp_exp;

  logic [15:0] lfsr;
  int          cyc = 0;
  int          rel_cyc;
  int          resp_lat;
  int          err_cnt;
  int          chk_cnt;
  int          test_err;
  int          last_cyc;
  int          strobe_cyc;
  logic [31:0] last_rdata;

  sim_host_top i_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .load_pkt_i   (load_pkt_i),
    .load_v_i     (load_v_i),
    .core_cmd_i   (core_cmd_i),
    .core_cmd_v_i (core_cmd_v_i),
    .core_resp_o  (core_resp_o),
    .core_resp_v_o(core_resp_v_o),
    .finish_o     (finish_o),
    .trace_en_o   (trace_en_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
    begin
      $display("Run stopped at cycle %0d before all tests completed", cyc);
      $display("Finished with errors");
      $finish;
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // One strobe on either or both ports, then an idle cycle
  task automatic issue_op(input logic load_en, input sim_host_pkg::load_pkt_t lp,
                          input logic core_en, input sim_host_pkg::mem_cmd_t cmd,
                          input logic chk);
    exp_t                                e;
    logic                                host;
    logic [sim_host_pkg::HOST_OFS_W-1:0] ofs;
    logic [sim_host_pkg::RAM_ADDR_W-1:0] idx;
    @(posedge clk_i);
    if (load_en)
    begin
      load_pkt_i <= lp;
      load_v_i   <= 1'b1;
      ram_model[lp.addr[sim_host_pkg::RAM_ADDR_W-1:0]] = lp.data;
      ram_known[lp.addr[sim_host_pkg::RAM_ADDR_W-1:0]] = 1'b1;
    end
    if (core_en)
    begin
      core_cmd_i   <= cmd;
      core_cmd_v_i <= 1'b1;
      host   = cmd.addr[sim_host_pkg::HOST_SEL_BIT];
      ofs    = cmd.addr[sim_host_pkg::HOST_OFS_W-1:0];
      idx    = cmd.addr[sim_host_pkg::RAM_ADDR_W-1:0];
      e.chk  = chk;
      e.cyc  = cyc;
      e.data = '0;
      strobe_cyc = cyc;
      if (cmd.wr && !host)
      begin
        ram_model[idx] = cmd.data;
        ram_known[idx] = 1'b1;
      end
      else if (cmd.wr && ofs == sim_host_pkg::REG_FINISH)
        finish_model = finish_model | cmd.data[sim_host_pkg::NUM_CORES-1:0];
      else if (cmd.wr && ofs == sim_host_pkg::REG_TRACE)
        trace_model = cmd.data[sim_host_pkg::NUM_TRACE-1:0];
      else if (!cmd.wr && !host)
        e.data = ram_model[idx];
      else if (!cmd.wr && ofs == sim_host_pkg::REG_FINISH)
        e.data = finish_model;
      else if (!cmd.wr && ofs == sim_host_pkg::REG_TRACE)
        e.data = trace_model;
      exp_q.push_back(e);
    end
    @(posedge clk_i);
    load_v_i     <= 1'b0;
    core_cmd_v_i <= 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      err_cnt++;
      $display("Core responses missing, %0d commands never answered", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s done with %0d errors", name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  // Response checker with latency counted from the drive edge to the sampling edge
  always @(posedge clk_i)
  begin
    if (!reset_i && core_resp_v_o)
    begin
      if (exp_q.size() == 0)
      begin
        err_cnt++;
        $display("Core response arrived with no command outstanding");
      end
      else
      begin
        resp_exp   = exp_q.pop_front();
        resp_lat   = cyc - resp_exp.cyc;
        last_rdata = core_resp_o.data;
        last_cyc   = cyc;
        chk_cnt++;
        assert (resp_lat >= 3 && resp_lat <= 4)
        else
        begin
          err_cnt++;
          $display("Core response came %0d cycles after its command", resp_lat);
        end
        if (resp_exp.chk)
          compare_value("core_resp_o", core_resp_o.data, resp_exp.data);
      end
    end
  end

  initial
  begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] w;
    logic [31:0] la;
    logic [31:0] ld;
    logic [31:0] t0;
    reset_i      = 1'b1;
    load_pkt_i   = '0;
    load_v_i     = 1'b0;
    core_cmd_i   = '0;
    core_cmd_v_i = 1'b0;
    lfsr         = 16'd15;
    finish_model = '0;
    trace_model  = '0;
    err_cnt      = 0;
    chk_cnt      = 0;
    test_err     = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    rel_cyc = cyc;

    repeat (4)
    begin
      @(posedge clk_i);
      compare_value("core_resp_v_o", core_resp_v_o, '0);
      compare_value("finish_o", finish_o, '0);
      compare_value("trace_en_o", trace_en_o, '0);
    end
    report_test("1 reset state");

    for (int i = 0; i < N_LOAD; i++)
    begin
      take_bits(32, d);
      issue_op(1'b1, {16'(i), d}, 1'b0, '0, 1'b0);
    end
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < N_LOAD; i++)
      issue_op(1'b0, '0, 1'b1, {1'b0, 16'(i), 32'h0}, 1'b1);
    drain_responses();
    report_test("2 loader then core read");

    for (int i = 0; i < N_RW; i++)
    begin
      take_bits(1, w);
      take_bits(4, a);
      take_bits(32, d);
      a = a + 32'h100;
      if (!ram_known[a[9:0]])
        w = 32'd1;
      issue_op(1'b0, '0, 1'b1, {w[0], a[15:0], d}, 1'b1);
    end
    drain_responses();
    report_test("3 core write and read");

    // Loader stays in its own region so core reads never race it
    for (int i = 0; i < N_CONC; i++)
    begin
      take_bits(1, w);
      take_bits(4, a);
      take_bits(32, d);
      take_bits(5, la);
      take_bits(32, ld);
      a = a + 32'h100;
      if (!ram_known[a[9:0]])
        w = 32'd1;
      issue_op(1'b1, {la[15:0] + 16'h200, ld}, 1'b1, {w[0], a[15:0], d}, 1'b1);
    end
    drain_responses();
    for (int i = 0; i < 32; i++)
    begin
      if (ram_known[10'h200 + i])
        issue_op(1'b0, '0, 1'b1, {1'b0, 16'h200 + 16'(i), 32'h0}, 1'b1);
    end
    drain_responses();
    report_test("4 concurrent ports");

    for (int i = 0; i < 3; i++)
    begin
      take_bits(4, d);
      issue_op(1'b0, '0, 1'b1, {1'b1, HOST_BASE + sim_host_pkg::REG_FINISH, d}, 1'b1);
      drain_responses();
      @(posedge clk_i);
      compare_value("finish_o", finish_o, finish_model);
      take_bits(8, d);
      issue_op(1'b0, '0, 1'b1, {1'b1, HOST_BASE + sim_host_pkg::REG_TRACE, d}, 1'b1);
      drain_responses();
      @(posedge clk_i);
      compare_value("trace_en_o", trace_en_o, trace_model);
      issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + sim_host_pkg::REG_FINISH, 32'h0}, 1'b1);
      issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + sim_host_pkg::REG_TRACE, 32'h0}, 1'b1);
    end
    take_bits(32, d);
    issue_op(1'b0, '0, 1'b1, {1'b1, HOST_BASE + sim_host_pkg::REG_RT_TIME, d}, 1'b1);
    issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + sim_host_pkg::REG_FINISH, 32'h0}, 1'b1);
    issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + sim_host_pkg::REG_TRACE, 32'h0}, 1'b1);
    issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + 16'd3, 32'h0}, 1'b1);
    drain_responses();
    @(posedge clk_i);
    compare_value("finish_o", finish_o, finish_model);
    compare_value("trace_en_o", trace_en_o, trace_model);
    report_test("5 host registers");

    issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + sim_host_pkg::REG_RT_TIME, 32'h0}, 1'b0);
    a = strobe_cyc;
    drain_responses();
    t0 = last_rdata;
    d  = (last_cyc - rel_cyc) / sim_host_pkg::RT_DIV;
    chk_cnt++;
    assert (t0 + 1 >= d && t0 <= d + 1)
    else
    begin
      err_cnt++;
      $display("** Error: core_resp_o = 0x%08h, expected within one of 0x%08h", t0, d);
    end
    while (cyc < a + 39)
      @(posedge clk_i);
    issue_op(1'b0, '0, 1'b1, {1'b0, HOST_BASE + sim_host_pkg::REG_RT_TIME, 32'h0}, 1'b0);
    drain_responses();
    chk_cnt++;
    assert (last_rdata - t0 >= 4 && last_rdata - t0 <= 5)
    else
    begin
      err_cnt++;
      $display("** Error: core_resp_o step = 0x%08h, expected 0x4 or 0x5", last_rdata - t0);
    end
    report_test("6 real-time counter");

    $display("Tests run: 6, checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/sim_host_pkg.sv
design/request_queue.sv
design/bus_arbiter.sv
design/backing_ram.sv
design/host_ctrl.sv
design/sim_host_top.sv
tb/tb_sim_host.sv

// ==== Bender.yml ====
package:
  name: sim_host

sources:
  - design/sim_host_pkg.sv
  - design/request_queue.sv
  - design/bus_arbiter.sv
  - design/backing_ram.sv
  - design/host_ctrl.sv
  - design/sim_host_top.sv
  - target: test
    files:
      - tb/tb_sim_host.sv
